// File: common/softmax_defines.svh
// Softmax block constants
// Q16.16 element format, tile geometry and the exp/ln scaling constants

`ifndef SOFTMAX_DEFINES_SVH
`define SOFTMAX_DEFINES_SVH

`define SM_WIDTH    32      // Element width
`define SM_FRAC     16      // Fraction bits

`define SM_TILE     4       // Elements per tile
// Must be a multiple of SM_TILE
`define SM_TOTAL    32

// Q16.16 constants
`define SM_LN2_Q    45426   // ln 2
`define SM_LOG2E_Q  94548   // log2 e

`endif

// File: common/softmax_pkg.sv
// Softmax shared types
// Element, tile and exp-sum formats plus the controller phases

`include "softmax_defines.svh"

package softmax_pkg;

    localparam int NUM_TILES = `SM_TOTAL / `SM_TILE;
    localparam int IDX_W     = (NUM_TILES > 1) ? $clog2(NUM_TILES) : 1;
    localparam int SUM_W     = `SM_WIDTH + $clog2(`SM_TOTAL + 1);

    typedef logic signed [`SM_WIDTH-1:0] elem_t;

    // Element 0 sits in the most significant slot
    typedef elem_t [0:`SM_TILE-1] tile_t;

    typedef logic [SUM_W-1:0] sum_t;   // Unsigned sum of exp values

    typedef enum logic [2:0] {
        IDLE,
        LOAD,       // Pass 0, store tiles and track max
        PASS_1,     // Exp and sum
        LN,
        PASS_2,     // Exp with ln offset, stream out
        DONE
    } phase_e;

endpackage

// File: hdl/softmax_ctrl.sv
// Softmax pass sequencer
// Steps LOAD, PASS_1, LN and PASS_2 and tracks tiles in the read pipeline

`include "softmax_defines.svh"

module softmax_ctrl import softmax_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic in_valid,
    input  logic tile_last,
    output logic cnt_clear,
    output logic cnt_step,
    output logic wr_en,
    output logic stats_clear,
    output logic max_en,
    output logic sum_en,
    output logic ln_en,
    output logic sel_ln,
    output logic out_valid,
    output logic done
);

    localparam logic [1:0] DRAIN = 2'd2;   // Buffer read plus exp register

    phase_e     phase, phase_nxt;
    logic [1:0] issue_v;      // Issue bit delayed by one and two cycles
    logic [1:0] wait_cnt;     // Drain count in read passes, LN wait otherwise
    logic       launch, accept, issue;
    logic       done_q;

    assign launch = start && (phase == IDLE || phase == DONE);
    assign accept = in_valid && phase == LOAD;

    // Reads issue every cycle of a read pass until the last tile is out
    assign issue = (phase == PASS_1 || phase == PASS_2) && wait_cnt == 2'd0;

    assign cnt_clear   = launch;
    assign stats_clear = launch;
    assign cnt_step    = accept || issue;
    assign wr_en       = accept;
    assign max_en      = accept;
    assign sum_en      = issue_v[1] && phase == PASS_1;
    assign out_valid   = issue_v[1] && phase == PASS_2;
    assign ln_en       = phase == LN && wait_cnt == 2'd0;   // Sum has settled here
    assign sel_ln      = phase == PASS_2;
    assign done        = done_q;

    always_comb begin
        phase_nxt = phase;
        case (phase)
            IDLE, DONE: phase_nxt = launch ? LOAD : IDLE;
            LOAD:       if (accept && tile_last) phase_nxt = PASS_1;
            PASS_1:     if (wait_cnt == DRAIN) phase_nxt = LN;
            LN:         if (wait_cnt == 2'd1) phase_nxt = PASS_2;
            PASS_2:     if (wait_cnt == DRAIN) phase_nxt = DONE;
            default:    phase_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase    <= IDLE;
            issue_v  <= 2'b00;
            wait_cnt <= 2'd0;
            done_q   <= 1'b0;
        end else begin
            phase   <= phase_nxt;
            issue_v <= {issue_v[0], issue};
            done_q  <= phase == PASS_2 && phase_nxt == DONE;
            if (phase_nxt != phase)
                wait_cnt <= 2'd0;
            else if (issue && tile_last)
                wait_cnt <= 2'd1;                   // Last read issued, drain
            else if (wait_cnt != 2'd0 || phase == LN)
                wait_cnt <= wait_cnt + 2'd1;
        end
    end

    // Every output beat was issued inside PASS_2
    a_out_in_pass2: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(phase, 2) == PASS_2);

    // No read of an earlier vector is still in flight during a write
    a_wr_in_load: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> issue_v == 2'b00);

endmodule

// File: hdl/softmax_vec.sv
// Softmax over a tiled vector
// Three passes over a tile buffer, log-sum-exp form, one tile per cycle

`include "softmax_defines.svh"

module softmax_vec import softmax_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  tile_t in_tile,
    input  logic  in_valid,
    output tile_t out_tile,
    output logic  out_valid,
    output logic  done
);

    logic             cnt_clear, cnt_step, wr_en;
    logic             stats_clear, max_en, sum_en, ln_en, sel_ln;
    logic [IDX_W-1:0] tile_idx;
    logic             tile_last;
    tile_t            rd_tile;
    elem_t            max_val, ln_sum, offset;
    sum_t             sum;

    // PASS_2 also subtracts ln of the sum
    assign offset = sel_ln ? max_val + ln_sum : max_val;

    softmax_ctrl ctrl_i (
        .clk(clk), .rst_n(rst_n), .start(start), .in_valid(in_valid),
        .tile_last(tile_last), .cnt_clear(cnt_clear), .cnt_step(cnt_step),
        .wr_en(wr_en), .stats_clear(stats_clear), .max_en(max_en),
        .sum_en(sum_en), .ln_en(ln_en), .sel_ln(sel_ln),
        .out_valid(out_valid), .done(done)
    );

    tile_counter cnt_i (
        .clk(clk), .rst_n(rst_n), .clear(cnt_clear), .step(cnt_step),
        .tile_idx(tile_idx), .tile_last(tile_last)
    );

    // Writes and reads never share a phase, so one index serves both
    tile_buffer buf_i (
        .clk(clk), .wr_en(wr_en), .wr_addr(tile_idx), .wr_tile(in_tile),
        .rd_addr(tile_idx), .rd_tile(rd_tile)
    );

    exp_tile exp_i (
        .clk(clk), .rst_n(rst_n), .in_tile(rd_tile), .offset(offset),
        .out_tile(out_tile)
    );

    tile_stats stats_i (
        .clk(clk), .rst_n(rst_n), .clear(stats_clear), .max_en(max_en),
        .in_tile(in_tile), .sum_en(sum_en), .exp_tile_in(out_tile),
        .max_val(max_val), .sum(sum)
    );

    ln_unit ln_i (
        .clk(clk), .rst_n(rst_n), .en(ln_en), .sum(sum), .ln_sum(ln_sum)
    );

endmodule

// File: hdl/tile_buffer.sv
// Tile buffer
// One write port and one registered read port, one tile per word

`include "softmax_defines.svh"

module tile_buffer import softmax_pkg::*; (
    input  logic             clk,
    input  logic             wr_en,
    input  logic [IDX_W-1:0] wr_addr,
    input  tile_t            wr_tile,
    input  logic [IDX_W-1:0] rd_addr,
    output tile_t            rd_tile
);

    tile_t mem [NUM_TILES];

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_tile;
        rd_tile <= mem[rd_addr];    // Data one cycle after the address
    end

    // Address steps without a write only in a read pass.
    // No write may then land on the word being read
    a_no_rw_clash: assert property (@(posedge clk)
        (!$past(wr_en) && rd_addr != $past(rd_addr)) |-> !(wr_en && wr_addr == rd_addr));

endmodule

// File: hdl/tile_counter.sv
// Tile index counter
// Shared by the load and both read passes, wraps after the last tile

`include "softmax_defines.svh"

module tile_counter import softmax_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             clear,
    input  logic             step,
    output logic [IDX_W-1:0] tile_idx,
    output logic             tile_last
);

    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_TILES - 1);

    assign tile_last = tile_idx == LAST_IDX;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tile_idx <= '0;
        end else if (clear) begin
            tile_idx <= '0;
        end else if (step) begin
            tile_idx <= tile_last ? '0 : tile_idx + 1'b1;   // Next pass starts at 0
        end
    end

    // Clear only comes between passes, never together with a step
    a_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
        !(clear && step));

endmodule

// File: run.sh
#!/bin/sh
# Builds the softmax testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_softmax_vec -f verilog.f \
    && ./obj_dir/Vtb_softmax_vec \
    || { echo "softmax simulation failed"; exit 1; }
echo "softmax simulation passed"

// File: softmax_math/exp_tile.sv
// Tile exp unit
// Registered exp(x - offset) per element, Mitchell style 2^t approximation

`include "softmax_defines.svh"

module exp_tile import softmax_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  tile_t in_tile,
    input  elem_t offset,
    output tile_t out_tile
);

    localparam int SH_W = $clog2(`SM_WIDTH);

    function automatic elem_t exp_elem(elem_t x, elem_t off);
        logic signed [`SM_WIDTH:0] d;
        logic signed [63:0]        t;
        logic signed [63:0]        n_neg;
        logic [`SM_FRAC:0]         base;
        d = x - off;
        if (d > 0)
            d = '0;                                         // Clamp to at most 0
        t = (64'(d) * 64'(`SM_LOG2E_Q)) >>> `SM_FRAC;       // Exponent in base 2
        n_neg = -(t >>> `SM_FRAC);                          // Minus the integer part
        base = {1'b1, t[`SM_FRAC-1:0]};                     // 1 + fraction
        if (n_neg >= `SM_WIDTH)
            exp_elem = '0;                                  // Underflows to zero
        else
            exp_elem = elem_t'(base >> n_neg[SH_W-1:0]);
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_tile <= '0;
        end else begin
            for (int i = 0; i < `SM_TILE; i++) begin
                out_tile[i] <= exp_elem(in_tile[i], offset);
            end
        end
    end

endmodule

// File: softmax_math/ln_unit.sv
// Natural log of the exp sum
// ln(s) = log2(s) * ln 2 with a linear mantissa between powers of two

`include "softmax_defines.svh"

module ln_unit import softmax_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  en,
    input  sum_t  sum,
    output elem_t ln_sum
);

    int                  k;         // Leading one position
    sum_t                norm;
    logic [`SM_FRAC-1:0] mant;
    logic signed [63:0]  lg;        // log2 of the sum in Q16.16
    logic signed [63:0]  prod;

    always_comb begin
        k = 0;
        for (int b = 0; b < SUM_W; b++) begin
            if (sum[b])
                k = b;
        end
        // Put the leading one at bit 16
        if (k >= `SM_FRAC)
            norm = sum >> (k - `SM_FRAC);
        else
            norm = sum << (`SM_FRAC - k);
        mant = norm[`SM_FRAC-1:0];
        lg   = ((64'(k) - 64'(`SM_FRAC)) <<< `SM_FRAC) + $signed(64'(mant));
        prod = lg * 64'(`SM_LN2_Q);
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            ln_sum <= '0;
        else if (en)
            ln_sum <= elem_t'(prod >>> `SM_FRAC);
    end

    // One strobe per vector, and never on an empty sum
    a_sum_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        en |-> sum != '0 ##1 !en);

endmodule

// File: softmax_math/tile_stats.sv
// Vector statistics
// Running maximum over the input tiles and the sum of exp tiles

`include "softmax_defines.svh"

module tile_stats import softmax_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  clear,
    input  logic  max_en,
    input  tile_t in_tile,
    input  logic  sum_en,
    input  tile_t exp_tile_in,
    output elem_t max_val,
    output sum_t  sum
);

    localparam elem_t MOST_NEG = {1'b1, {(`SM_WIDTH-1){1'b0}}};

    elem_t tile_max;
    sum_t  tile_sum;

    always_comb begin
        elem_t e;
        tile_max = in_tile[0];
        tile_sum = '0;
        for (int i = 1; i < `SM_TILE; i++) begin
            e = in_tile[i];
            if (e > tile_max)
                tile_max = e;
        end
        for (int i = 0; i < `SM_TILE; i++) begin
            tile_sum = tile_sum + sum_t'($unsigned(exp_tile_in[i]));   // Exp values are >= 0
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            max_val <= MOST_NEG;
            sum     <= '0;
        end else begin
            if (max_en && tile_max > max_val)
                max_val <= tile_max;
            if (sum_en)
                sum <= sum + tile_sum;
        end
    end

endmodule

// File: tb/tb_softmax_model.svh
// Softmax reference model
// Bit-exact Q16.16 exp, ln and whole-vector softmax for the testbench

`ifndef TB_SOFTMAX_MODEL_SVH
`define TB_SOFTMAX_MODEL_SVH

// Keep the low element-width bits, signed
function automatic longint wrap_elem(longint v);
    int w;
    w = int'(v);
    return w;
endfunction

// exp(x - off) as 2^t with a linear fraction
function automatic longint exp_of_diff(longint x, longint off);
    longint d;
    longint t;
    longint n;
    longint f;
    d = x - off;
    if (d > 0)
        d = 0;
    t = (d * `SM_LOG2E_Q) >>> `SM_FRAC;
    n = t >>> `SM_FRAC;             // Floor of t
    f = t & 64'hffff;               // t mod 65536
    if (-n >= `SM_WIDTH)
        return 0;
    return (longint'(65536) + f) >> (-n);
endfunction

// ln(s) from the leading one and the 16 bits below it
function automatic longint ln_of_sum(longint s);
    int     k;
    longint m;
    longint lg;
    k = 0;
    for (int b = 0; b < SUM_W; b++) begin
        if (s[b])
            k = b;
    end
    if (k >= `SM_FRAC)
        m = (s >> (k - `SM_FRAC)) & 64'hffff;
    else
        m = (s << (`SM_FRAC - k)) & 64'hffff;
    lg = (longint'(k - `SM_FRAC) <<< `SM_FRAC) + m;
    return (lg * `SM_LN2_Q) >>> `SM_FRAC;
endfunction

// Log-sum-exp softmax over one vector
function automatic void softmax_expected(input int x [`SM_TOTAL], output int y [`SM_TOTAL]);
    longint mx;
    longint s;
    longint off;
    mx = x[0];
    for (int i = 1; i < `SM_TOTAL; i++) begin
        if (x[i] > mx)
            mx = x[i];
    end
    s = 0;
    for (int i = 0; i < `SM_TOTAL; i++)
        s = s + exp_of_diff(x[i], mx);
    s = s & ((longint'(1) <<< SUM_W) - 1);         // Sum register width
    off = wrap_elem(mx + wrap_elem(ln_of_sum(s))); // Offset adder is one element wide
    for (int i = 0; i < `SM_TOTAL; i++)
        y[i] = int'(exp_of_diff(x[i], off));
endfunction

`endif

// File: tb/tb_softmax_vec.sv
// Softmax testbench
// Random tiled vectors against the reference model, with burst and done checks

`include "softmax_defines.svh"

module tb_softmax_vec import softmax_pkg::*; ();

    localparam int NUM_RUNS        = 9;
    localparam int WATCHDOG_CYCLES = NUM_RUNS * (NUM_TILES * 8 + 100);
    localparam int ONE             = 1 << `SM_FRAC;   // 1.0 in Q16.16

    logic  clk = 1'b0;
    logic  rst_n, start, in_valid;
    tile_t in_tile, out_tile;
    logic  out_valid, done;

    int    vec   [`SM_TOTAL];
    int    exp_y [`SM_TOTAL];
    tile_t exp_q [$];          // Expected output tiles in order
    string name_q [$];
    int    beat_cnt  = 0;
    int    runs_done = 0;
    logic  prev_ov   = 1'b0;

    `include "tb_softmax_model.svh"

    softmax_vec dut_i (
        .clk(clk), .rst_n(rst_n), .start(start), .in_tile(in_tile),
        .in_valid(in_valid), .out_tile(out_tile), .out_valid(out_valid), .done(done)
    );

    always #4 clk = ~clk;

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first error");
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    function automatic tile_t pack_tile(input int v [`SM_TOTAL], input int t);
        tile_t r;
        for (int j = 0; j < `SM_TILE; j++)
            r[j] = elem_t'(v[t * `SM_TILE + j]);   // Element 0 in the top slot
        return r;
    endfunction

    task automatic fill_random(input int lo, input int span);
        for (int i = 0; i < `SM_TOTAL; i++)
            vec[i] = lo + int'($urandom_range(span));
    endtask

    // Queue the expected tiles, then pulse start
    task automatic launch_run(input string name);
        softmax_expected(vec, exp_y);
        for (int t = 0; t < NUM_TILES; t++) begin
            exp_q.push_back(pack_tile(exp_y, t));
            name_q.push_back(name);
        end
        start = 1'b1;
        tick();
        start = 1'b0;
    endtask

    task automatic run_vector(input string name, input int max_gap);
        launch_run(name);
        for (int t = 0; t < NUM_TILES; t++) begin
            repeat (int'($urandom_range(max_gap))) tick();
            in_valid = 1'b1;
            in_tile  = pack_tile(vec, t);
            tick();
            in_valid = 1'b0;
        end
        while (!done)
            tick();     // Leaves us inside the DONE cycle
    endtask

    task automatic check_beat();
        tile_t exp_t;
        string name;
        assert (exp_q.size() > 0) else report_fail("out_valid high with no output expected");
        assert (!done) else report_fail("done high during an output beat");
        assert (beat_cnt == 0 || prev_ov) else report_fail("gap inside the output burst");
        assert (beat_cnt < NUM_TILES) else report_fail("too many output beats in one run");
        exp_t = exp_q.pop_front();
        name  = name_q.pop_front();
        for (int j = 0; j < `SM_TILE; j++) begin
            assert (out_tile[j] == exp_t[j])
                else report_fail($sformatf("MISMATCH %s tile %0d elem %0d: expected %0d, actual %0d",
                                           name, beat_cnt, j, exp_t[j], out_tile[j]));
        end
        beat_cnt++;
    endtask

    // Output collector, sampled away from the driving edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (out_valid) begin
                check_beat();
            end else if (done) begin
                assert (beat_cnt == NUM_TILES && prev_ov)
                    else report_fail("done pulse not right after a full output burst");
                beat_cnt = 0;
                runs_done++;
            end else begin
                assert (beat_cnt == 0)
                    else report_fail("output burst cut short or done missing after it");
            end
            prev_ov = out_valid;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_fail($sformatf("timeout, run not finished after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        void'($urandom(32'hcda8));
        rst_n    = 1'b0;
        start    = 1'b0;
        in_valid = 1'b0;
        in_tile  = '0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;

        repeat (10) begin
            tick();
            assert (!out_valid && !done) else report_fail("out_valid or done high before start");
        end

        fill_random(-8 * ONE, 16 * ONE);
        run_vector("random_nogap", 0);
        repeat (3) tick();
        repeat (4) begin
            fill_random(-8 * ONE, 16 * ONE);
            run_vector("random_gaps", 3);
            repeat (2) tick();
        end

        // Second vector launched in the DONE cycle with a lower maximum
        fill_random(-8 * ONE, 16 * ONE);
        vec[5] = 8 * ONE;
        run_vector("b2b_first", 3);
        fill_random(-8 * ONE, 12 * ONE);
        run_vector("b2b_second", 2);
        repeat (2) tick();

        fill_random(-8 * ONE, 16 * ONE);
        for (int i = 1; i < `SM_TOTAL; i++)
            vec[i] = vec[0];
        run_vector("all_equal", 1);
        repeat (2) tick();

        fill_random(-8 * ONE, 16 * ONE);
        vec[$urandom_range(`SM_TOTAL - 1)] = 40 * ONE;   // Others underflow to 0
        run_vector("one_spike", 2);
        repeat (4) tick();

        if (runs_done == NUM_RUNS && exp_q.size() == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("only %0d of %0d runs completed", runs_done, NUM_RUNS);
            $display("ERRORS FOUND");
            $fatal(1, "incomplete runs");
        end
    end

endmodule

// File: verilog.f
+incdir+common
+incdir+tb
common/softmax_pkg.sv
hdl/tile_counter.sv
hdl/tile_buffer.sv
softmax_math/exp_tile.sv
softmax_math/ln_unit.sv
softmax_math/tile_stats.sv
hdl/softmax_ctrl.sv
hdl/softmax_vec.sv
tb/tb_softmax_vec.sv
